//--- hdl/ram_port_if.sv
// ------------------------------
// One RAM port. Write when en and wr are both high,
// otherwise a read when en is high.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

interface ram_port_if #(
    parameter int ADDR_WID = 8,
    parameter int DATA_WID = 64
);
    logic                en;
    logic                wr;
    logic [ADDR_WID-1:0] addr;
    logic [DATA_WID-1:0] wr_data;
    logic [DATA_WID-1:0] rd_data;

    // Side that issues accesses
    modport controller (
        output en,
        output wr,
        output addr,
        output wr_data,
        input  rd_data
    );

    // RAM side
    modport memory (
        input  en,
        input  wr,
        input  addr,
        input  wr_data,
        output rd_data
    );

endinterface : ram_port_if

`default_nettype wire

//--- hdl/stats_init_fsm.sv
// ------------------------------
// Startup sequencer. init_done stays high until the next reset
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module stats_init_fsm (
    input  logic clk,
    input  logic reset,
    input  logic sweep_last,
    output logic sweep_enable,
    output logic clearing,
    output logic init_done
);

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        READY
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                state_next = CLEAR;
            end
            // Leave once the final index has been written
            CLEAR: begin
                if (sweep_last) begin
                    state_next = READY;
                end
            end
            READY: begin
                state_next = READY;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            init_done <= 1'b0;
        end else begin
            state     <= state_next;
            init_done <= (state == READY);
        end
    end

    assign sweep_enable = (state == CLEAR);
    assign clearing     = (state == CLEAR);

endmodule : stats_init_fsm

`default_nettype wire

//--- hdl/stats_sweep_counter.sv
// ------------------------------
// Index walker for the clear sweep, wraps after the last index
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module stats_sweep_counter #(
    parameter int ADDR_WID = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    output logic [ADDR_WID-1:0] index,
    output logic                last
);

    always_ff @(posedge clk) begin
        if (reset) begin
            index <= '0;
        end else if (enable) begin
            index <= index + 1'b1;
        end
    end

    // All ones is the final table entry
    assign last = &index;

endmodule : stats_sweep_counter

`default_nettype wire

//--- hdl/stats_table.sv
// ------------------------------
// Per-index packet and byte counters. Strobes before init_done
// are dropped; updates and queries must not share a cycle.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module stats_table #(
    parameter int                        ADDR_WID = 8,
    parameter xilinx_ram_pkg::opt_mode_t OPT_MODE = xilinx_ram_pkg::OPT_MODE_TIMING
) (
    input  logic                                 clk,
    input  logic                                 reset,

    input  logic                                 update_strobe,
    input  logic [ADDR_WID-1:0]                  update_index,
    input  logic [15:0]                          update_length,

    input  logic                                 query_strobe,
    input  logic [ADDR_WID-1:0]                  query_index,

    output logic                                 query_valid,
    output logic [xilinx_ram_pkg::STATS_FIELD_WID-1:0] query_packets,
    output logic [xilinx_ram_pkg::STATS_FIELD_WID-1:0] query_bytes,

    output logic                                 init_done
);
    import xilinx_ram_pkg::*;

    logic                sweep_enable;
    logic                sweep_last;
    logic                clearing;
    logic [ADDR_WID-1:0] clear_index;
    stats_entry_t        query_entry;

    // A reads for updates and queries, B writes
    ram_port_if #(.ADDR_WID(ADDR_WID), .DATA_WID($bits(stats_entry_t))) port_a ();
    ram_port_if #(.ADDR_WID(ADDR_WID), .DATA_WID($bits(stats_entry_t))) port_b ();

    stats_init_fsm stats_init_fsm_inst (
        .clk          (clk),
        .reset        (reset),
        .sweep_last   (sweep_last),
        .sweep_enable (sweep_enable),
        .clearing     (clearing),
        .init_done    (init_done)
    );

    stats_sweep_counter #(.ADDR_WID(ADDR_WID)) stats_sweep_counter_inst (
        .clk    (clk),
        .reset  (reset),
        .enable (sweep_enable),
        .index  (clear_index),
        .last   (sweep_last)
    );

    stats_update_pipe #(.ADDR_WID(ADDR_WID), .OPT_MODE(OPT_MODE)) stats_update_pipe_inst (
        .clk           (clk),
        .reset         (reset),
        .clearing      (clearing),
        .ready         (init_done),
        .clear_index   (clear_index),
        .update_strobe (update_strobe),
        .update_index  (update_index),
        .update_length (update_length),
        .query_strobe  (query_strobe),
        .query_index   (query_index),
        .query_valid   (query_valid),
        .query_entry   (query_entry),
        .rd_port       (port_a.controller),
        .wr_port       (port_b.controller)
    );

    xilinx_ram_tdp_uram #(
        .ADDR_WID (ADDR_WID),
        .DATA_WID ($bits(stats_entry_t)),
        .OPT_MODE (OPT_MODE)
    ) xilinx_ram_tdp_uram_inst (
        .clk       (clk),
        .en_a      (port_a.en),
        .wr_a      (port_a.wr),
        .addr_a    (port_a.addr),
        .wr_data_a (port_a.wr_data),
        .rd_data_a (port_a.rd_data),
        .en_b      (port_b.en),
        .wr_b      (port_b.wr),
        .addr_b    (port_b.addr),
        .wr_data_b (port_b.wr_data),
        .rd_data_b (port_b.rd_data)
    );

    assign query_packets = query_entry.packets;
    assign query_bytes   = query_entry.bytes;

endmodule : stats_table

`default_nettype wire

//--- hdl/stats_update_pipe.sv
// ------------------------------
// Read-modify-write of statistics entries. Queries see no forwarding;
// an update and a query in the same cycle are not supported.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module stats_update_pipe #(
    parameter int                        ADDR_WID = 8,
    parameter xilinx_ram_pkg::opt_mode_t OPT_MODE = xilinx_ram_pkg::OPT_MODE_TIMING
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         clearing,
    input  logic                         ready,
    input  logic [ADDR_WID-1:0]          clear_index,
    input  logic                         update_strobe,
    input  logic [ADDR_WID-1:0]          update_index,
    input  logic [15:0]                  update_length,
    input  logic                         query_strobe,
    input  logic [ADDR_WID-1:0]          query_index,
    output logic                         query_valid,
    output xilinx_ram_pkg::stats_entry_t query_entry,
    ram_port_if.controller               rd_port,
    ram_port_if.controller               wr_port
);
    import xilinx_ram_pkg::*;

    localparam int RD_LATENCY = 1 + get_uram_rd_pipeline_stages(ADDR_WID, OPT_MODE);
    // Write-back history entries
    localparam int DEPTH = RD_LATENCY + 1;

    logic                  accept_update;
    logic                  accept_query;
    logic [ADDR_WID-1:0]   rd_index;

    logic [RD_LATENCY-1:0] flight_valid;
    logic                  flight_query  [RD_LATENCY];
    logic [ADDR_WID-1:0]   flight_index  [RD_LATENCY];
    logic [15:0]           flight_length [RD_LATENCY];

    logic [DEPTH-1:0]      hist_valid;
    logic [ADDR_WID-1:0]   hist_index [DEPTH];
    stats_entry_t          hist_entry [DEPTH];

    logic                  ret_valid;
    logic                  ret_query;
    logic [ADDR_WID-1:0]   ret_index;
    logic [15:0]           ret_length;
    logic                  writeback;
    stats_entry_t          base_entry;
    stats_entry_t          updated_entry;

    // ------------------------------
    // Issue on port A
    // ------------------------------
    assign accept_update = ready & update_strobe;
    assign accept_query  = ready & query_strobe;
    assign rd_index      = accept_query ? query_index : update_index;

    assign rd_port.en      = accept_update | accept_query;
    assign rd_port.wr      = 1'b0;
    assign rd_port.addr    = rd_index;
    assign rd_port.wr_data = '0;

    // ------------------------------
    // In-flight tracking and history
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            flight_valid <= '0;
            hist_valid   <= '0;
        end else begin
            // Oldest stage drops off once its data has returned
            flight_valid <= RD_LATENCY'({flight_valid, rd_port.en});
            // One slot per cycle, so the history covers every write the RAM read missed
            hist_valid   <= {hist_valid[DEPTH-2:0], writeback};
        end
    end

    always_ff @(posedge clk) begin
        flight_query[0]  <= accept_query;
        flight_index[0]  <= rd_index;
        flight_length[0] <= update_length;
        for (int i = 1; i < RD_LATENCY; i++) begin
            flight_query[i]  <= flight_query[i-1];
            flight_index[i]  <= flight_index[i-1];
            flight_length[i] <= flight_length[i-1];
        end
    end

    always_ff @(posedge clk) begin
        hist_index[0] <= ret_index;
        hist_entry[0] <= updated_entry;
        for (int i = 1; i < DEPTH; i++) begin
            hist_index[i] <= hist_index[i-1];
            hist_entry[i] <= hist_entry[i-1];
        end
    end

    // Stage matching the cycle the RAM data lands
    assign ret_valid  = flight_valid[RD_LATENCY-1];
    assign ret_query  = flight_query[RD_LATENCY-1];
    assign ret_index  = flight_index[RD_LATENCY-1];
    assign ret_length = flight_length[RD_LATENCY-1];
    assign writeback  = ret_valid & ~ret_query;

    // ------------------------------
    // Merge and write back
    // ------------------------------
    // Oldest first, so the newest match wins
    always_comb begin
        base_entry = rd_port.rd_data;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (hist_valid[i] && (hist_index[i] == ret_index)) begin
                base_entry = hist_entry[i];
            end
        end
    end

    assign updated_entry.packets = base_entry.packets + STATS_FIELD_WID'(1);
    assign updated_entry.bytes   = base_entry.bytes + STATS_FIELD_WID'(ret_length);

    // Clear sweep owns port B until ready
    assign wr_port.en      = clearing | writeback;
    assign wr_port.wr      = 1'b1;
    assign wr_port.addr    = clearing ? clear_index : ret_index;
    assign wr_port.wr_data = clearing ? '0 : updated_entry;

    // Query return
    assign query_valid = ret_valid & ret_query;
    assign query_entry = rd_port.rd_data;

endmodule : stats_update_pipe

`default_nettype wire

//--- hdl/xilinx_ram_pkg.sv
// ------------------------------
// Shared RAM options and the statistics entry layout.
// Counters are plain unsigned fields that wrap.
// ------------------------------
`default_nettype none

package xilinx_ram_pkg;

    // ------------------------------
    // RAM build options
    // ------------------------------
    typedef enum logic [1:0] {
        OPT_MODE_TIMING,
        OPT_MODE_LATENCY
    } opt_mode_t;

    // Extra registers behind the URAM output.
    // Total read latency is one plus this count
    function automatic int get_uram_rd_pipeline_stages(
        input int        addr_wid,
        input opt_mode_t opt_mode
    );
        if (opt_mode == OPT_MODE_LATENCY) begin
            return 0;
        end
        // Deeper arrays cascade more URAM blocks, so add a stage
        if (addr_wid <= 12) begin
            return 1;
        end
        return 2;
    endfunction

    // ------------------------------
    // Statistics entry
    // ------------------------------
    localparam int STATS_FIELD_WID = 32;

    // One RAM word per index
    typedef struct packed {
        logic [STATS_FIELD_WID-1:0] packets;
        logic [STATS_FIELD_WID-1:0] bytes;
    } stats_entry_t;

endpackage : xilinx_ram_pkg

`default_nettype wire

//--- hdl/xilinx_ram_tdp_uram.sv
// ------------------------------
// True dual-port UltraRAM, no reset and no initial contents.
// Same-address read and write on one edge returns old data.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module xilinx_ram_tdp_uram #(
    parameter int                        ADDR_WID = 8,
    parameter int                        DATA_WID = 64,
    parameter xilinx_ram_pkg::opt_mode_t OPT_MODE = xilinx_ram_pkg::OPT_MODE_TIMING
) (
    input  logic                clk,

    // Port A
    input  logic                en_a,
    input  logic                wr_a,
    input  logic [ADDR_WID-1:0] addr_a,
    input  logic [DATA_WID-1:0] wr_data_a,
    output logic [DATA_WID-1:0] rd_data_a,

    // Port B
    input  logic                en_b,
    input  logic                wr_b,
    input  logic [ADDR_WID-1:0] addr_b,
    input  logic [DATA_WID-1:0] wr_data_b,
    output logic [DATA_WID-1:0] rd_data_b
);
    import xilinx_ram_pkg::*;

    localparam int DEPTH = 2**ADDR_WID;
    localparam int RD_PIPELINE_STAGES = get_uram_rd_pipeline_stages(ADDR_WID, OPT_MODE);

    typedef logic [DATA_WID-1:0] data_t;

    // ------------------------------
    // Storage and port access
    // ------------------------------
    (* ram_style = "ultra" *) data_t mem [DEPTH];

    data_t raw_rd_a;
    data_t raw_rd_b;

    always @(posedge clk) begin
        if (en_a) begin
            if (wr_a) begin
                mem[addr_a] <= wr_data_a;
            end else begin
                raw_rd_a <= mem[addr_a];
            end
        end
    end

    always @(posedge clk) begin
        if (en_b) begin
            if (wr_b) begin
                mem[addr_b] <= wr_data_b;
            end else begin
                raw_rd_b <= mem[addr_b];
            end
        end
    end

    // ------------------------------
    // Output register stages
    // ------------------------------
    // Index 0 is port A, index 1 is port B
    logic  rd_issue [2];
    data_t raw_rd   [2];
    data_t rd_out   [2];

    assign rd_issue[0] = en_a & ~wr_a;
    assign rd_issue[1] = en_b & ~wr_b;
    assign raw_rd[0]   = raw_rd_a;
    assign raw_rd[1]   = raw_rd_b;

    for (genvar p = 0; p < 2; p++) begin : g_port
        if (RD_PIPELINE_STAGES > 0) begin : g_pipe
            logic  rd_en_p   [RD_PIPELINE_STAGES];
            data_t rd_data_p [RD_PIPELINE_STAGES];

            // Read marker travels with the data so idle cycles hold the output
            always_ff @(posedge clk) begin
                rd_en_p[0] <= rd_issue[p];
                for (int i = 1; i < RD_PIPELINE_STAGES; i++) begin
                    rd_en_p[i] <= rd_en_p[i-1];
                end
            end

            always_ff @(posedge clk) begin
                if (rd_en_p[0]) begin
                    rd_data_p[0] <= raw_rd[p];
                end
                for (int i = 1; i < RD_PIPELINE_STAGES; i++) begin
                    if (rd_en_p[i]) begin
                        rd_data_p[i] <= rd_data_p[i-1];
                    end
                end
            end

            assign rd_out[p] = rd_data_p[RD_PIPELINE_STAGES-1];
        end : g_pipe
        else begin : g_no_pipe
            assign rd_out[p] = raw_rd[p];
        end : g_no_pipe
    end : g_port

    assign rd_data_a = rd_out[0];
    assign rd_data_b = rd_out[1];

endmodule : xilinx_ram_tdp_uram

`default_nettype wire

//--- list.f
hdl/xilinx_ram_pkg.sv
hdl/ram_port_if.sv
hdl/xilinx_ram_tdp_uram.sv
hdl/stats_sweep_counter.sv
hdl/stats_init_fsm.sv
hdl/stats_update_pipe.sv
hdl/stats_table.sv
test/stats_table_checker.sv
test/stats_table_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the stats_table testbench with Verilator; sim.log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module stats_table_tb \
    -f list.f -o stats_table_sim > build.log 2>&1 \
    && ./obj_dir/stats_table_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "Build or simulation returned an error status, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx ">>> PASS" sim.log && exit 0 || exit 1

//--- test/stats_table_checker.sv
// ------------------------------
// Timing rules of stats_table, bound into every instance.
// Query latency holds only for strobes taken while init_done is high.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module stats_table_checker #(
    parameter int                        ADDR_WID = 8,
    parameter xilinx_ram_pkg::opt_mode_t OPT_MODE = xilinx_ram_pkg::OPT_MODE_TIMING
) (
    input logic clk,
    input logic reset,
    input logic query_strobe,
    input logic query_valid,
    input logic init_done
);
    import xilinx_ram_pkg::*;

    localparam int RD_LATENCY = 1 + get_uram_rd_pipeline_stages(ADDR_WID, OPT_MODE);
    // Edges from the first one that samples reset low to the one that sees init_done high
    localparam int INIT_CYCLES = 2**ADDR_WID + 2;

    // Failed assertions so far
    int failure_count = 0;

    // Result comes straight off the RAM read port
    query_latency_check: assert property (@(posedge clk) disable iff (reset)
        (query_strobe && init_done) |-> ##RD_LATENCY query_valid)
    else begin
        $error("query_valid did not follow query_strobe after %0d cycles", RD_LATENCY);
        failure_count++;
    end

    query_source_check: assert property (@(posedge clk) disable iff (reset)
        query_valid |-> $past(query_strobe && init_done, RD_LATENCY))
    else begin
        $error("query_valid high without a query_strobe %0d cycles earlier", RD_LATENCY);
        failure_count++;
    end

    query_before_init_check: assert property (@(posedge clk) disable iff (reset)
        !init_done |-> !query_valid)
    else begin
        $error("query_valid high while init_done is low");
        failure_count++;
    end

    init_hold_check: assert property (@(posedge clk)
        !reset |-> !$fell(init_done))
    else begin
        $error("init_done fell without reset");
        failure_count++;
    end

    // One IDLE cycle, the full sweep, then the registered flag
    init_timing_check: assert property (@(posedge clk)
        $fell(reset) |-> ##INIT_CYCLES $rose(init_done))
    else begin
        $error("init_done did not rise %0d cycles after reset fell", INIT_CYCLES);
        failure_count++;
    end

endmodule : stats_table_checker

bind stats_table stats_table_checker #(
    .ADDR_WID (ADDR_WID),
    .OPT_MODE (OPT_MODE)
) stats_table_checker_inst (
    .clk          (clk),
    .reset        (reset),
    .query_strobe (query_strobe),
    .query_valid  (query_valid),
    .init_done    (init_done)
);

`default_nettype wire

//--- test/stats_table_tb.sv
// ------------------------------
// Clear, update and query checks of stats_table against a model.
// Queries go out only after the update pipeline has drained.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module stats_table_tb;
    import xilinx_ram_pkg::*;

    localparam int        ADDR_WID        = 8;
    localparam opt_mode_t OPT_MODE        = OPT_MODE_TIMING;
    localparam int        DEPTH           = 2**ADDR_WID;
    localparam int        RD_LATENCY      = 1 + get_uram_rd_pipeline_stages(ADDR_WID, OPT_MODE);
    localparam int        INIT_TIMEOUT    = DEPTH + 64;
    localparam int        QUERY_TIMEOUT   = 4 * RD_LATENCY + 8;
    localparam int        WATCHDOG_CYCLES = 20000;

    logic                       clk;
    logic                       reset;
    logic                       update_strobe;
    logic [ADDR_WID-1:0]        update_index;
    logic [15:0]                update_length;
    logic                       query_strobe;
    logic [ADDR_WID-1:0]        query_index;
    logic                       query_valid;
    logic [STATS_FIELD_WID-1:0] query_packets;
    logic [STATS_FIELD_WID-1:0] query_bytes;
    logic                       init_done;

    // Expected contents of every entry
    logic [STATS_FIELD_WID-1:0] model_packets [DEPTH];
    logic [STATS_FIELD_WID-1:0] model_bytes   [DEPTH];
    int                         mismatch_count;
    int                         timeout_count;

    stats_table #(.ADDR_WID(ADDR_WID), .OPT_MODE(OPT_MODE)) stats_table_inst (
        .clk           (clk),
        .reset         (reset),
        .update_strobe (update_strobe),
        .update_index  (update_index),
        .update_length (update_length),
        .query_strobe  (query_strobe),
        .query_index   (query_index),
        .query_valid   (query_valid),
        .query_packets (query_packets),
        .query_bytes   (query_bytes),
        .init_done     (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display(">>> FAIL");
        $finish;
    end

    task automatic idle_cycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    task automatic send_update(input logic [ADDR_WID-1:0] index, input logic [15:0] length);
        update_strobe = 1'b1;
        update_index  = index;
        update_length = length;
        model_packets[index] += STATS_FIELD_WID'(1);
        model_bytes[index]   += STATS_FIELD_WID'(length);
        @(negedge clk);
        update_strobe = 1'b0;
    endtask

    // Last write-back lands RD_LATENCY edges after its strobe
    task automatic drain_pipeline();
        idle_cycles(RD_LATENCY + 3);
    endtask

    task automatic wait_for_init();
        int waited;
        waited = 0;
        while (!init_done && waited < INIT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!init_done) begin
            $display("Timeout: init_done did not rise after reset");
            timeout_count++;
        end
    endtask

    task automatic check_entry(input logic [ADDR_WID-1:0] index);
        int waited;
        query_strobe = 1'b1;
        query_index  = index;
        @(negedge clk);
        query_strobe = 1'b0;
        waited = 0;
        while (!query_valid && waited < QUERY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!query_valid) begin
            $display("Timeout: no query result came back for index %0d", index);
            timeout_count++;
        end else begin
            assert (query_packets == model_packets[index] && query_bytes == model_bytes[index])
            else begin
                $display("MISMATCH %0t: index %0d packets %0d expected %0d bytes %0d expected %0d",
                         $time, index, query_packets, model_packets[index],
                         query_bytes, model_bytes[index]);
                mismatch_count++;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        logic [ADDR_WID-1:0] hot_index [8];
        logic [ADDR_WID-1:0] index;
        int                  assertion_failures;
        void'($urandom(50));
        reset          = 1'b1;
        update_strobe  = 1'b0;
        update_index   = '0;
        update_length  = '0;
        query_strobe   = 1'b0;
        query_index    = '0;
        mismatch_count = 0;
        timeout_count  = 0;
        for (int i = 0; i < DEPTH; i++) begin
            model_packets[i] = '0;
            model_bytes[i]   = '0;
        end

        // ------------------------------
        // Reset and clear sweep
        // ------------------------------
        idle_cycles(10);
        assert (!init_done) else begin
            $display("MISMATCH %0t: init_done high during reset", $time);
            mismatch_count++;
        end
        reset = 1'b0;
        // A query during the clear sweep is dropped
        idle_cycles(4);
        query_strobe = 1'b1;
        query_index  = '0;
        @(negedge clk);
        query_strobe = 1'b0;
        wait_for_init();
        repeat (16) check_entry(ADDR_WID'($urandom_range(DEPTH - 1, 0)));

        // Single update
        index = ADDR_WID'($urandom_range(DEPTH - 1, 0));
        send_update(index, 16'($urandom_range(16'hffff, 1)));
        drain_pipeline();
        check_entry(index);

        // Same index on every cycle exercises forwarding
        index = ADDR_WID'($urandom_range(DEPTH - 1, 0));
        repeat (20) send_update(index, 16'($urandom_range(16'hffff, 0)));
        drain_pipeline();
        check_entry(index);

        // ------------------------------
        // Random traffic over a small hot set
        // ------------------------------
        for (int i = 0; i < 8; i++) begin
            hot_index[i] = ADDR_WID'($urandom_range(DEPTH - 1, 0));
        end
        repeat (200) begin
            send_update(hot_index[$urandom_range(7, 0)], 16'($urandom_range(16'hffff, 0)));
            idle_cycles($urandom_range(3, 0));
        end
        drain_pipeline();
        for (int i = 0; i < 8; i++) begin
            check_entry(hot_index[i]);
        end

        // Whole table, untouched entries must still be zero
        for (int i = 0; i < DEPTH; i++) begin
            check_entry(ADDR_WID'(i));
        end

        assertion_failures = stats_table_inst.stats_table_checker_inst.failure_count;
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count, assertion_failures);
        if (mismatch_count + timeout_count + assertion_failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : stats_table_tb

`default_nettype wire
